/* src/decode_consts.svh */
// Decoder constants: data widths, field widths and func7 encodings for RV32IM
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath and instruction width
`define XLEN        32

// Instruction field widths
`define REG_ADDR_W  5
`define OPCODE_W    7
`define FUNCT3_W    3

// ALU operation code and ALU class widths
`define ALU_CTRL_W  5
`define ALU_OP_W    3

// func7 patterns for register-ALU and shift decoding
`define FUNCT7_BASE   7'b0000000
`define FUNCT7_ALT    7'b0100000
`define FUNCT7_MULDIV 7'b0000001

`endif

/* src/decodePkg.sv */
// Decode types: major opcodes, ALU operation codes and ALU classes
`include "decode_consts.svh"

package decodePkg;

    // Kept RV32I major opcodes
    typedef enum logic [`OPCODE_W-1:0] {
        opLoad   = 7'b0000011,
        opOpImm  = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

    // Operation codes seen by the execute stage ALU
    typedef enum logic [`ALU_CTRL_W-1:0] {
        aluAnd    = 5'd0,
        aluOr     = 5'd1,
        aluAdd    = 5'd2,
        aluXor    = 5'd3,
        aluSub    = 5'd4,
        aluSll    = 5'd6,
        aluSrl    = 5'd7,
        aluSra    = 5'd8,
        aluSlt    = 5'd9,
        aluSltu   = 5'd10,
        aluMul    = 5'd11,
        aluMulh   = 5'd12,
        aluMulhsu = 5'd13,
        aluMulhu  = 5'd14,
        aluDiv    = 5'd15,
        aluDivu   = 5'd16,
        aluRem    = 5'd17,
        aluRemu   = 5'd18
    } aluCtrlT;

    // Instruction class, tells execute where the operands come from
    typedef enum logic [`ALU_OP_W-1:0] {
        classMem    = 3'd0,
        classBranch = 3'd1,
        classArith  = 3'd2,
        classJal    = 3'd3,
        classLui    = 3'd4,
        classAuipc  = 3'd5,
        classJalr   = 3'd7
    } aluOpT;

endpackage

/* src/decodeStageReg.sv */
// Decode stage register: holds instruction, PC and register operands, frozen by stall
`include "decode_consts.svh"

module decodeStageReg (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic [`XLEN-1:0] nextInstruction,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] regValue1,
    input  logic [`XLEN-1:0] regValue2,
    output logic [`XLEN-1:0] instruction,
    output logic [`XLEN-1:0] capturedPc,
    output logic [`XLEN-1:0] operand1,
    output logic [`XLEN-1:0] operand2
);

    // Reset value decodes as an unknown opcode, so all controls idle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            instruction <= '0;
            capturedPc  <= '0;
            operand1    <= '0;
            operand2    <= '0;
        end
        else if (!stall)
        begin
            instruction <= nextInstruction;
            capturedPc  <= pc;
            operand1    <= regValue1;
            operand2    <= regValue2;
        end
    end

endmodule

/* src/immGen.sv */
// Immediate generator: sign-extended immediate selected by instruction format
`include "decode_consts.svh"

module immGen (
    input  logic [`XLEN-1:0] instruction,
    output logic [`XLEN-1:0] imm
);

    logic sign;

    assign sign = instruction[31];

    always_comb
    begin
        case (instruction[`OPCODE_W-1:0])
            // U format
            decodePkg::opLui,
            decodePkg::opAuipc:
                imm = {instruction[31:12], 12'b0};
            // J format, offset in halfwords
            decodePkg::opJal:
                imm = {{12{sign}}, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            // B format
            decodePkg::opBranch:
                imm = {{20{sign}}, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            // S format, split around rd position
            decodePkg::opStore:
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            // I format
            decodePkg::opJalr,
            decodePkg::opLoad,
            decodePkg::opOpImm:
                imm = {{20{sign}}, instruction[31:20]};
            default:
                imm = '0;
        endcase
    end

endmodule

/* src/mainControl.sv */
// Main control: opcode decode into memory, writeback, branch and ALU class controls
`include "decode_consts.svh"

module mainControl (
    input  logic                 [`XLEN-1:0]     instruction,
    output logic                                 memWrite,
    output logic                                 memRead,
    output logic                                 regWrite,
    output logic                                 aluSrc,
    output logic                                 memToReg,
    output logic                                 pcSrc,
    output decodePkg::aluOpT                     aluOp,
    output logic                 [`FUNCT3_W-1:0] branchType
);

    logic [`FUNCT3_W-1:0] func3;

    assign func3 = instruction[14:12];

    always_comb
    begin
        // Idle controls, also the result for unknown opcodes
        memWrite   = 1'b0;
        memRead    = 1'b0;
        regWrite   = 1'b0;
        aluSrc     = 1'b0;
        memToReg   = 1'b0;
        pcSrc      = 1'b0;
        aluOp      = decodePkg::classMem;
        branchType = '0;

        case (instruction[`OPCODE_W-1:0])
            decodePkg::opLui:
            begin
                aluOp    = decodePkg::classLui;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::opAuipc:
            begin
                aluOp    = decodePkg::classAuipc;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            // Jumps write the link address to rd
            decodePkg::opJal:
            begin
                aluOp    = decodePkg::classJal;
                regWrite = 1'b1;
                pcSrc    = 1'b1;
            end
            decodePkg::opJalr:
            begin
                aluOp    = decodePkg::classJalr;
                regWrite = 1'b1;
                pcSrc    = 1'b1;
            end
            decodePkg::opBranch:
            begin
                aluOp      = decodePkg::classBranch;
                pcSrc      = 1'b1;
                branchType = func3;
            end
            decodePkg::opLoad:
            begin
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::opStore:
            begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            decodePkg::opOpImm:
            begin
                aluOp    = decodePkg::classArith;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::opOp:
            begin
                aluOp    = decodePkg::classArith;
                regWrite = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

endmodule

/* src/aluControl.sv */
// ALU control: opcode, func3 and func7 mapped onto the five-bit ALU operation
`include "decode_consts.svh"

module aluControl (
    input  logic              [`XLEN-1:0] instruction,
    output decodePkg::aluCtrlT            aluControl
);

    logic [`FUNCT3_W-1:0] func3;
    logic [6:0]           func7;

    assign func3 = instruction[14:12];
    assign func7 = instruction[31:25];

    always_comb
    begin
        aluControl = decodePkg::aluAnd;

        case (instruction[`OPCODE_W-1:0])
            // Address and link computations are plain adds
            decodePkg::opLui,
            decodePkg::opAuipc,
            decodePkg::opJal,
            decodePkg::opJalr,
            decodePkg::opLoad,
            decodePkg::opStore:
                aluControl = decodePkg::aluAdd;
            // Branch compare by subtraction
            decodePkg::opBranch:
                aluControl = decodePkg::aluSub;
            decodePkg::opOpImm:
            begin
                case (func3)
                    3'b000: aluControl = decodePkg::aluAdd;
                    3'b001: aluControl = decodePkg::aluSll;
                    3'b010: aluControl = decodePkg::aluSlt;
                    3'b011: aluControl = decodePkg::aluSltu;
                    3'b100: aluControl = decodePkg::aluXor;
                    3'b101:
                    begin
                        // func7 picks logical or arithmetic shift
                        if (func7 == `FUNCT7_BASE)
                            aluControl = decodePkg::aluSrl;
                        else if (func7 == `FUNCT7_ALT)
                            aluControl = decodePkg::aluSra;
                    end
                    3'b110: aluControl = decodePkg::aluOr;
                    default: aluControl = decodePkg::aluAnd;
                endcase
            end
            decodePkg::opOp:
            begin
                if (func7 == `FUNCT7_BASE)
                begin
                    case (func3)
                        3'b000: aluControl = decodePkg::aluAdd;
                        3'b001: aluControl = decodePkg::aluSll;
                        3'b010: aluControl = decodePkg::aluSlt;
                        3'b011: aluControl = decodePkg::aluSltu;
                        3'b100: aluControl = decodePkg::aluXor;
                        3'b101: aluControl = decodePkg::aluSrl;
                        3'b110: aluControl = decodePkg::aluOr;
                        default: aluControl = decodePkg::aluAnd;
                    endcase
                end
                else if (func7 == `FUNCT7_ALT)
                begin
                    if (func3 == 3'b000)
                        aluControl = decodePkg::aluSub;
                    else if (func3 == 3'b101)
                        aluControl = decodePkg::aluSra;
                end
                else if (func7 == `FUNCT7_MULDIV)
                begin
                    // RV32M, codes follow func3 order
                    case (func3)
                        3'b000: aluControl = decodePkg::aluMul;
                        3'b001: aluControl = decodePkg::aluMulh;
                        3'b010: aluControl = decodePkg::aluMulhsu;
                        3'b011: aluControl = decodePkg::aluMulhu;
                        3'b100: aluControl = decodePkg::aluDiv;
                        3'b101: aluControl = decodePkg::aluDivu;
                        3'b110: aluControl = decodePkg::aluRem;
                        default: aluControl = decodePkg::aluRemu;
                    endcase
                end
            end
            default:
                aluControl = decodePkg::aluAnd;
        endcase
    end

endmodule

/* src/instrDecode.sv */
// Decode stage top: stage register feeding immediate, main control and ALU control decoders
`include "decode_consts.svh"

module instrDecode (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  stall,
    input  logic               [`XLEN-1:0]       nextInstruction,
    input  logic               [`XLEN-1:0]       pc,
    input  logic               [`XLEN-1:0]       regValue1,
    input  logic               [`XLEN-1:0]       regValue2,
    output logic               [`XLEN-1:0]       imm,
    output logic               [`REG_ADDR_W-1:0] rs1,
    output logic               [`REG_ADDR_W-1:0] rs2,
    output logic               [`REG_ADDR_W-1:0] regDest,
    output logic                                  memWrite,
    output logic                                  memRead,
    output logic                                  regWrite,
    output logic                                  aluSrc,
    output decodePkg::aluOpT                      aluOp,
    output logic                                  memToReg,
    output logic                                  pcSrc,
    output logic               [`FUNCT3_W-1:0]   branchType,
    output decodePkg::aluCtrlT                    aluControl,
    output logic               [`XLEN-1:0]       pcOut,
    output logic               [`XLEN-1:0]       value1,
    output logic               [`XLEN-1:0]       value2
);

    logic [`XLEN-1:0] instruction;

    decodeStageReg stageReg (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .nextInstruction (nextInstruction),
        .pc              (pc),
        .regValue1       (regValue1),
        .regValue2       (regValue2),
        .instruction     (instruction),
        .capturedPc      (pcOut),
        .operand1        (value1),
        .operand2        (value2)
    );

    // Register fields sit at fixed positions in every format
    assign rs1     = instruction[19:15];
    assign rs2     = instruction[24:20];
    assign regDest = instruction[11:7];

    immGen immUnit (
        .instruction (instruction),
        .imm         (imm)
    );

    mainControl ctrlUnit (
        .instruction (instruction),
        .memWrite    (memWrite),
        .memRead     (memRead),
        .regWrite    (regWrite),
        .aluSrc      (aluSrc),
        .memToReg    (memToReg),
        .pcSrc       (pcSrc),
        .aluOp       (aluOp),
        .branchType  (branchType)
    );

    aluControl aluCtrlUnit (
        .instruction (instruction),
        .aluControl  (aluControl)
    );

endmodule

/* tests/instrDecode_properties.sv */
// Decode stage checker: concurrent assertions on capture, stall hold and decode rules
`include "decode_consts.svh"

module instrDecodeProperties (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 stall,
    input logic               [`XLEN-1:0]       nextInstruction,
    input logic               [`XLEN-1:0]       pc,
    input logic               [`XLEN-1:0]       regValue1,
    input logic               [`XLEN-1:0]       regValue2,
    input logic               [`XLEN-1:0]       imm,
    input logic               [`REG_ADDR_W-1:0] rs1,
    input logic               [`REG_ADDR_W-1:0] rs2,
    input logic               [`REG_ADDR_W-1:0] regDest,
    input logic                                 memWrite,
    input logic                                 memRead,
    input logic                                 regWrite,
    input logic                                 aluSrc,
    input decodePkg::aluOpT                     aluOp,
    input logic                                 memToReg,
    input logic                                 pcSrc,
    input logic               [2:0]             branchType,
    input decodePkg::aluCtrlT                   aluControl,
    input logic               [`XLEN-1:0]       pcOut,
    input logic               [`XLEN-1:0]       value1,
    input logic               [`XLEN-1:0]       value2
);

    int failCount = 0;

    // Immediate by format, sign from bit 31
    function automatic logic [`XLEN-1:0] expectedImm(input logic [`XLEN-1:0] i);
        case (i[6:0])
            decodePkg::opLui,
            decodePkg::opAuipc:
                return {i[31:12], 12'h000};
            decodePkg::opJal:
                return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            decodePkg::opBranch:
                return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            decodePkg::opStore:
                return {{20{i[31]}}, i[31:25], i[11:7]};
            decodePkg::opJalr,
            decodePkg::opLoad,
            decodePkg::opOpImm:
                return {{20{i[31]}}, i[31:20]};
            default:
                return '0;
        endcase
    endfunction

    // Bits: memWrite memRead regWrite aluSrc memToReg pcSrc, then class and branch type
    function automatic logic [11:0] expectedCtrl(input logic [`XLEN-1:0] i);
        case (i[6:0])
            decodePkg::opLui:    return {6'b001100, decodePkg::classLui, 3'b000};
            decodePkg::opAuipc:  return {6'b001100, decodePkg::classAuipc, 3'b000};
            decodePkg::opJal:    return {6'b001001, decodePkg::classJal, 3'b000};
            decodePkg::opJalr:   return {6'b001001, decodePkg::classJalr, 3'b000};
            decodePkg::opBranch: return {6'b000001, decodePkg::classBranch, i[14:12]};
            decodePkg::opLoad:   return {6'b011110, decodePkg::classMem, 3'b000};
            decodePkg::opStore:  return {6'b100100, decodePkg::classMem, 3'b000};
            decodePkg::opOpImm:  return {6'b001100, decodePkg::classArith, 3'b000};
            decodePkg::opOp:     return {6'b001000, decodePkg::classArith, 3'b000};
            default:             return 12'h000;
        endcase
    endfunction

    function automatic logic [`ALU_CTRL_W-1:0] expectedAlu(input logic [`XLEN-1:0] i);
        logic [2:0]             f3;
        logic [6:0]             f7;
        logic [`ALU_CTRL_W-1:0] base;
        f3 = i[14:12];
        f7 = i[31:25];
        case (f3)
            3'd0: base = decodePkg::aluAdd;
            3'd1: base = decodePkg::aluSll;
            3'd2: base = decodePkg::aluSlt;
            3'd3: base = decodePkg::aluSltu;
            3'd4: base = decodePkg::aluXor;
            3'd5: base = decodePkg::aluSrl;
            3'd6: base = decodePkg::aluOr;
            default: base = decodePkg::aluAnd;
        endcase
        case (i[6:0])
            decodePkg::opBranch:
                return decodePkg::aluSub;
            // Shift right needs a valid func7, other immediates ignore it
            decodePkg::opOpImm:
                if (f3 == 3'd5 && f7 == `FUNCT7_ALT)
                    return decodePkg::aluSra;
                else if (f3 == 3'd5 && f7 != `FUNCT7_BASE)
                    return decodePkg::aluAnd;
                else
                    return base;
            decodePkg::opOp:
                if (f7 == `FUNCT7_BASE)
                    return base;
                else if (f7 == `FUNCT7_ALT)
                    return (f3 == 3'd0) ? decodePkg::aluSub :
                           (f3 == 3'd5) ? decodePkg::aluSra : decodePkg::aluAnd;
                else if (f7 == `FUNCT7_MULDIV)
                    return decodePkg::aluMul + {2'b00, f3};
                else
                    return decodePkg::aluAnd;
            decodePkg::opLui,
            decodePkg::opAuipc,
            decodePkg::opJal,
            decodePkg::opJalr,
            decodePkg::opLoad,
            decodePkg::opStore:
                return decodePkg::aluAdd;
            default:
                return decodePkg::aluAnd;
        endcase
    endfunction

    resetIdle: assert property (@(posedge clk) disable iff (rst)
        $past(rst) |-> imm == '0 && aluControl == decodePkg::aluAnd &&
        {memWrite, memRead, regWrite, aluSrc, memToReg, pcSrc, aluOp, branchType} == 12'h000)
    else
    begin
        $error("Control outputs or immediate not idle after reset");
        failCount++;
    end

    capturePass: assert property (@(posedge clk) disable iff (rst)
        $past(!rst && !stall) |-> value1 == $past(regValue1) && value2 == $past(regValue2) &&
        pcOut == $past(pc) && rs1 == $past(nextInstruction[19:15]) &&
        rs2 == $past(nextInstruction[24:20]) && regDest == $past(nextInstruction[11:7]))
    else
    begin
        $error("Operands, PC or register fields not passed through from capture");
        failCount++;
    end

    stallHold: assert property (@(posedge clk) disable iff (rst)
        $past(!rst && stall) |-> $stable(imm) && $stable(rs1) && $stable(rs2) &&
        $stable(regDest) && $stable(memWrite) && $stable(memRead) && $stable(regWrite) &&
        $stable(aluSrc) && $stable(aluOp) && $stable(memToReg) && $stable(pcSrc) &&
        $stable(branchType) && $stable(aluControl) && $stable(pcOut) &&
        $stable(value1) && $stable(value2))
    else
    begin
        $error("An output changed across a stalled edge");
        failCount++;
    end

    ctrlRule: assert property (@(posedge clk) disable iff (rst)
        $past(!rst && !stall) |->
        {memWrite, memRead, regWrite, aluSrc, memToReg, pcSrc, aluOp, branchType} ==
        expectedCtrl($past(nextInstruction)))
    else
    begin
        $error("Main control outputs differ from the opcode rule");
        failCount++;
    end

    immRule: assert property (@(posedge clk) disable iff (rst)
        $past(!rst && !stall) |-> imm == expectedImm($past(nextInstruction)))
    else
    begin
        $error("Immediate differs from the format rule");
        failCount++;
    end

    aluRule: assert property (@(posedge clk) disable iff (rst)
        $past(!rst && !stall) |-> aluControl == expectedAlu($past(nextInstruction)))
    else
    begin
        $error("ALU operation differs from the func3 and func7 rule");
        failCount++;
    end

endmodule

bind instrDecode instrDecodeProperties props (.*);

/* tests/instrDecodeTb.sv */
// Decode stage testbench driving directed and random instructions checked by bound assertions
`include "decode_consts.svh"

module instrDecodeTb;

    localparam int PERIOD        = 100;
    localparam int RESET_CYCLES  = 5;
    localparam int IDLE_CYCLES   = 2;
    localparam int OPCODE_ROUNDS = 4;
    localparam int ALU_CYCLES    = 56;
    localparam int STALL_CYCLES  = 40;
    localparam int UNKNOWN_COUNT = 4;
    // Every test also ends with two flush cycles
    localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + 9 * OPCODE_ROUNDS
                                   + ALU_CYCLES + STALL_CYCLES + UNKNOWN_COUNT + 10;
    localparam int WATCHDOG_TIME = (TOTAL_CYCLES + 20) * PERIOD;

    logic                     clk;
    logic                     rst;
    logic                     stall;
    logic [`XLEN-1:0]         nextInstruction;
    logic [`XLEN-1:0]         pc;
    logic [`XLEN-1:0]         regValue1;
    logic [`XLEN-1:0]         regValue2;
    logic [`XLEN-1:0]         imm;
    logic [`REG_ADDR_W-1:0]   rs1;
    logic [`REG_ADDR_W-1:0]   rs2;
    logic [`REG_ADDR_W-1:0]   regDest;
    logic                     memWrite;
    logic                     memRead;
    logic                     regWrite;
    logic                     aluSrc;
    decodePkg::aluOpT         aluOp;
    logic                     memToReg;
    logic                     pcSrc;
    logic [2:0]               branchType;
    decodePkg::aluCtrlT       aluControl;
    logic [`XLEN-1:0]         pcOut;
    logic [`XLEN-1:0]         value1;
    logic [`XLEN-1:0]         value2;

    logic [31:0] lcgState = 32'd49;
    logic [6:0]  keptOpcodes [9];
    logic [6:0]  func7List [3];
    logic [6:0]  unknownOpcodes [4];
    int          testsRun = 0;
    int          testsFailed = 0;
    int          failMark = 0;

    instrDecode UUT (.*);

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState ^ (lcgState >> 16);
    endfunction

    // One decode cycle with fresh PC and operands
    task automatic applyInstr(input logic [31:0] instr, input logic stallLevel);
        logic [31:0] pcWord;
        pcWord = nextRandom();
        @(posedge clk);
        nextInstruction <= instr;
        stall           <= stallLevel;
        pc              <= {pcWord[31:2], 2'b00};
        regValue1       <= nextRandom();
        regValue2       <= nextRandom();
    endtask

    // Last input is captured on the first edge and checked on the second
    task automatic finishTest(input string name);
        int newFailures;
        repeat (2) @(posedge clk);
        #1;
        newFailures = UUT.props.failCount - failMark;
        failMark    = UUT.props.failCount;
        testsRun++;
        if (newFailures != 0)
        begin
            testsFailed++;
            $display("Test %s: %0d assertion failures, outputs broke a decode rule",
                     name, newFailures);
        end
        else
            $display("Test %s: done, no assertion failed", name);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Watchdog: run passed %0d time units before the tests finished",
                 WATCHDOG_TIME);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        logic [31:0] word;
        logic [31:0] choice;
        int          pick;
        keptOpcodes = '{decodePkg::opLui, decodePkg::opAuipc, decodePkg::opJal,
                        decodePkg::opJalr, decodePkg::opBranch, decodePkg::opLoad,
                        decodePkg::opStore, decodePkg::opOpImm, decodePkg::opOp};
        func7List = '{`FUNCT7_BASE, `FUNCT7_ALT, `FUNCT7_MULDIV};
        unknownOpcodes = '{7'b0000000, 7'b0001111, 7'b1110011, 7'b1111111};
        rst             = 1'b1;
        stall           = 1'b0;
        nextInstruction = '0;
        pc              = '0;
        regValue1       = '0;
        regValue2       = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst   <= 1'b0;
        stall <= 1'b1;
        repeat (IDLE_CYCLES) applyInstr(nextRandom(), 1'b1);
        finishTest("resetIdle");

        for (int i = 0; i < 9; i++)
        begin
            for (int j = 0; j < OPCODE_ROUNDS; j++)
            begin
                word = nextRandom();
                applyInstr({word[31:7], keptOpcodes[i]}, 1'b0);
            end
        end
        finishTest("opcodeControlAndImm");

        // Register and immediate ALU forms under each func7 and then branch compares
        for (int i = 0; i < 2; i++)
        begin
            for (int j = 0; j < 3; j++)
            begin
                for (int k = 0; k < 8; k++)
                begin
                    word = nextRandom();
                    applyInstr({func7List[j], word[24:15], k[2:0], word[11:7],
                                (i == 0) ? decodePkg::opOp : decodePkg::opOpImm}, 1'b0);
                end
            end
        end
        for (int k = 0; k < 8; k++)
        begin
            word = nextRandom();
            applyInstr({word[31:15], k[2:0], word[11:7], decodePkg::opBranch}, 1'b0);
        end
        finishTest("aluOperations");

        for (int n = 0; n < STALL_CYCLES; n++)
        begin
            word   = nextRandom();
            choice = nextRandom();
            pick   = int'(choice[7:4]) % 9;
            applyInstr({word[31:7], keptOpcodes[pick]}, choice[0]);
        end
        finishTest("stallHold");

        for (int n = 0; n < UNKNOWN_COUNT; n++)
        begin
            word = nextRandom();
            applyInstr({word[31:7], unknownOpcodes[n]}, 1'b0);
        end
        finishTest("unknownOpcode");

        $display("Summary: %0d tests run, %0d failed, %0d assertion failures",
                 testsRun, testsFailed, UUT.props.failCount);
        if (testsFailed == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* instrDecode.f */
+incdir+src
src/decodePkg.sv
src/decodeStageReg.sv
src/immGen.sv
src/mainControl.sv
src/aluControl.sv
src/instrDecode.sv
tests/instrDecode_properties.sv
tests/instrDecodeTb.sv

/* run.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, and check the log
rm -rf obj_dir build.log sim.log
verilator --binary --assert --top-module instrDecodeTb -f instrDecode.f \
    -o instrDecodeSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/instrDecodeSim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
